// File: vlog.f
+incdir+verif
hw/bpu_pkg.sv
hw/bpu_tage.sv
hw/bpu_btb.sv
hw/bpu_redirect.sv
hw/bpu_top.sv
verif/bpu_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := bpu_tb
FILELIST := vlog.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))
HDRS     := $(wildcard verif/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: verif/bpu_model.svh
// reference tables, history and btb, updated with blocking writes
bpu_pkg::ctr_t m_bim     [512];
logic [9:0]    m_t0_tag  [256];
bpu_pkg::ctr_t m_t0_ctr  [256];
logic [9:0]    m_t1_tag  [256];
bpu_pkg::ctr_t m_t1_ctr  [256];
logic [15:0]   m_ghist;
logic          m_btb_vld [256];
logic [31:0]   m_btb_pc  [256];   // whole pc kept, bits 31:10 act as tag
logic [31:0]   m_btb_tgt [256];

function automatic void model_reset();
    m_ghist = 16'h0000;
    for (int i = 0; i < 512; i++) begin
        m_bim[i] = 2'b01;
    end
    for (int i = 0; i < 256; i++) begin
        m_t0_tag[i]  = 10'd0;
        m_t0_ctr[i]  = 2'b01;
        m_t1_tag[i]  = 10'd0;
        m_t1_ctr[i]  = 2'b01;
        m_btb_vld[i] = 1'b0;
        m_btb_pc[i]  = 32'd0;
        m_btb_tgt[i] = 32'd0;
    end
endfunction

function automatic bpu_pkg::ctr_t ctr_toward(input bpu_pkg::ctr_t c, input logic up);
    bpu_pkg::ctr_t n;
    n = c;
    if (up && c != 2'b11) n = c + 2'b01;
    if (!up && c != 2'b00) n = c - 2'b01;
    return n;
endfunction

function automatic bpu_pkg::pred_t model_predict(input logic [31:0] pc, input logic [31:0] word);
    bpu_pkg::pred_t p;
    logic [7:0]     i0;
    logic [7:0]     i1;
    logic [9:0]     k0;
    logic [9:0]     k1;
    logic [7:0]     bi;
    logic           dir;
    logic           hit;
    logic [31:0]    offs_b;
    logic [31:0]    offs_j;
    i0 = pc[7:0] ^ m_ghist[7:0];
    i1 = pc[7:0] ^ m_ghist[15:8];
    k0 = pc[17:8] ^ m_ghist[15:6];
    k1 = pc[17:8] ^ {2'b00, m_ghist[7:0]};
    p.provider = bpu_pkg::prov_bim;
    dir        = m_bim[pc[9:1]][1];
    if (m_t1_tag[i1][9:4] == k1[9:4]) begin   // longer history first
        p.provider = bpu_pkg::prov_t1;
        dir        = m_t1_ctr[i1][1];
    end else if (m_t0_tag[i0][9:4] == k0[9:4]) begin
        p.provider = bpu_pkg::prov_t0;
        dir        = m_t0_ctr[i0][1];
    end
    bi     = pc[9:2];
    hit    = m_btb_vld[bi] && m_btb_pc[bi][31:10] == pc[31:10];
    offs_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    offs_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    p.history = m_ghist;
    p.is_cf   = 1'b0;
    p.taken   = 1'b0;
    p.target  = pc + 32'd4;
    if (word[6:0] == bpu_pkg::opc_jal) begin
        p.is_cf  = 1'b1;
        p.taken  = 1'b1;
        p.target = hit ? m_btb_tgt[bi] : pc + offs_j;
    end else if (word[6:0] == bpu_pkg::opc_jalr) begin
        p.is_cf = 1'b1;
        p.taken = hit;
        if (hit) p.target = m_btb_tgt[bi];
    end else if (word[6:0] == bpu_pkg::opc_branch) begin
        p.is_cf = 1'b1;
        p.taken = dir;
        if (dir) p.target = hit ? m_btb_tgt[bi] : pc + offs_b;
    end
    return p;
endfunction

function automatic void model_update(input bpu_pkg::resolve_t r);
    logic [7:0] i0;
    logic [7:0] i1;
    logic [9:0] k0;
    logic [9:0] k1;
    i0 = r.pc[7:0] ^ r.history[7:0];
    i1 = r.pc[7:0] ^ r.history[15:8];
    k0 = r.pc[17:8] ^ r.history[15:6];
    k1 = r.pc[17:8] ^ {2'b00, r.history[7:0]};
    if (r.valid) begin
        m_bim[r.pc[9:1]] = ctr_toward(m_bim[r.pc[9:1]], r.taken);
        if (r.correct && r.provider == bpu_pkg::prov_t1) begin
            m_t1_ctr[i1] = ctr_toward(m_t1_ctr[i1], r.taken);
        end else if (r.correct && r.provider == bpu_pkg::prov_t0) begin
            m_t0_ctr[i0] = ctr_toward(m_t0_ctr[i0], r.taken);
        end else if (!r.correct && r.provider == bpu_pkg::prov_t1) begin
            m_t1_ctr[i1] = r.taken ? 2'b11 : 2'b00;   // forced on a miss
        end else if (!r.correct && r.provider == bpu_pkg::prov_t0) begin
            m_t0_ctr[i0] = r.taken ? 2'b11 : 2'b00;
        end else if (!r.correct) begin
            if (m_t1_tag[i1] != k1) begin
                m_t1_tag[i1] = k1;
                m_t1_ctr[i1] = r.taken ? 2'b10 : 2'b01;
            end else if (m_t0_tag[i0] != k0) begin
                m_t0_tag[i0] = k0;
                m_t0_ctr[i0] = r.taken ? 2'b10 : 2'b01;
            end
        end
        if (r.taken) begin
            m_btb_vld[r.pc[9:2]] = 1'b1;
            m_btb_pc[r.pc[9:2]]  = r.pc;
            m_btb_tgt[r.pc[9:2]] = r.target;
        end
        m_ghist = {m_ghist[14:0], r.taken};
    end
endfunction

// File: verif/bpu_tb.sv
`default_nettype none

module bpu_tb;

    localparam int clk_period    = 40;
    localparam int reset_cycles  = 8;
    localparam int num_cycles    = 4000;
    localparam int margin_cycles = 200;
    localparam int unsigned btb_entries = 256;   // model assumes pc[9:2] index

    logic              clk = 1'b0;
    logic              rst;
    logic [31:0]       fetch_pc;
    bpu_pkg::inst_u    fetch_inst;
    bpu_pkg::resolve_t resolve;
    bpu_pkg::pred_t    pred;

    logic [31:0] lfsr_q = 32'h8864e4e2;
    int          n_tagged;
    int          n_jalr_hit;

    `include "bpu_model.svh"

    bpu_top #(
        .btb_entries (btb_entries)
    ) bpu_top_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc_i   (fetch_pc),
        .fetch_inst_i (fetch_inst),
        .resolve_i    (resolve),
        .pred_o       (pred)
    );

    always #(clk_period / 2) clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // 4 word slots times 4 regions that alias in btb and bimodal
    function automatic logic [31:0] pool_pc(input logic [3:0] sel);
        return 32'h0000_2000 + {20'd0, sel[3:2], 6'd0, sel[1:0], 2'd0};
    endfunction

    function automatic string class_name(input logic [31:0] word);
        string s;
        case (word[6:0])
            bpu_pkg::opc_branch: s = "branch";
            bpu_pkg::opc_jal:    s = "jal";
            bpu_pkg::opc_jalr:   s = "jalr";
            default:             s = "other";
        endcase
        return s;
    endfunction

    function automatic string pred_text(input bpu_pkg::pred_t p);
        return $sformatf("cf=%b tk=%b tgt=%h prov=%0d hist=%h",
                         p.is_cf, p.taken, p.target, p.provider, p.history);
    endfunction

    task automatic stop_on_failure(input string why);
        $display("RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_pred(input string name, input bpu_pkg::pred_t exp,
                              input bpu_pkg::pred_t act);
        if (act !== exp) begin
            $display("error %s: expected %s, actual %s",
                     name, pred_text(exp), pred_text(act));
            stop_on_failure("prediction output differs from the model");
        end
    endtask

    task automatic drive_cycle();
        logic [31:0]       r;
        logic [31:0]       word;
        bpu_pkg::resolve_t rs;
        r        = take_bits(4);
        fetch_pc <= pool_pc(r[3:0]);
        r        = take_bits(2);
        word     = take_bits(25) << 7;
        case (r[1:0])
            2'd0: word[6:0] = bpu_pkg::opc_branch;
            2'd1: word[6:0] = bpu_pkg::opc_jal;
            2'd2: word[6:0] = bpu_pkg::opc_jalr;
            default: begin
                r         = take_bits(7);
                word[6:0] = r[6:0];
                if (class_name(word) != "other") word[6:0] = 7'b0010011;
            end
        endcase
        fetch_inst <= word;
        r          = take_bits(3);
        rs.valid   = r[2];
        rs.taken   = r[1];
        rs.correct = r[0];
        r          = take_bits(2);
        rs.provider = (r[1:0] == 2'd2) ? bpu_pkg::prov_t1 :
                      (r[1:0] == 2'd1) ? bpu_pkg::prov_t0 : bpu_pkg::prov_bim;
        r         = take_bits(4);
        rs.pc     = pool_pc(r[3:0]);
        r         = take_bits(30);
        rs.target = {r[29:0], 2'b00};
        r         = take_bits(1);
        rs.history = m_ghist;   // matches the lookup history half of the time
        if (!r[0]) begin
            r          = take_bits(16);
            rs.history = r[15:0];
        end
        resolve <= rs;
    endtask

    initial begin
        bpu_pkg::pred_t exp;
        rst        <= 1'b1;
        fetch_pc   <= 32'd0;
        fetch_inst <= 32'd0;
        resolve    <= '0;
        n_tagged   = 0;
        n_jalr_hit = 0;
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int cyc = 0; cyc < num_cycles; cyc++) begin
            @(posedge clk);
            drive_cycle();
            @(negedge clk);   // lookup settled before the resolve is applied
            exp = model_predict(fetch_pc, fetch_inst);
            check_pred($sformatf("%s lookup, cycle %0d", class_name(fetch_inst), cyc), exp, pred);
            if (exp.provider != bpu_pkg::prov_bim) n_tagged++;
            if (fetch_inst.b.opcode == bpu_pkg::opc_jalr && exp.taken) n_jalr_hit++;
            model_update(resolve);
        end
        if (n_tagged == 0 || n_jalr_hit == 0) begin
            stop_on_failure("stimulus never reached a tagged table or a jalr btb hit");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        #((reset_cycles + num_cycles + margin_cycles) * clk_period);
        stop_on_failure("watchdog timeout, the stimulus loop did not finish");
    end

endmodule

`default_nettype wire

// File: hw/bpu_top.sv
`default_nettype none

module bpu_top #(
    parameter int unsigned btb_entries = 256
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [bpu_pkg::xlen-1:0] fetch_pc_i,
    input  wire bpu_pkg::inst_u           fetch_inst_i,
    input  wire bpu_pkg::resolve_t        resolve_i,
    output bpu_pkg::pred_t                pred_o
);

    // direction path
    logic                         tage_taken;
    bpu_pkg::provider_e           tage_provider;
    logic [bpu_pkg::hist_len-1:0] tage_history;

    // target path
    logic                     btb_hit;
    logic [bpu_pkg::xlen-1:0] btb_target;

    bpu_tage bpu_tage_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (fetch_pc_i),
        .resolve_i   (resolve_i),
        .dir_taken_o (tage_taken),
        .provider_o  (tage_provider),
        .history_o   (tage_history)
    );

    bpu_btb #(
        .btb_entries (btb_entries)
    ) bpu_btb_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (fetch_pc_i),
        .resolve_i   (resolve_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    // final direction and next pc
    bpu_redirect bpu_redirect_i (
        .fetch_pc_i   (fetch_pc_i),
        .fetch_inst_i (fetch_inst_i),
        .dir_taken_i  (tage_taken),
        .provider_i   (tage_provider),
        .history_i    (tage_history),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pred_o       (pred_o)
    );

endmodule

`default_nettype wire

// File: hw/bpu_redirect.sv
`default_nettype none

module bpu_redirect (
    input  wire logic [bpu_pkg::xlen-1:0]     fetch_pc_i,
    input  wire bpu_pkg::inst_u               fetch_inst_i,
    input  wire logic                         dir_taken_i,
    input  wire bpu_pkg::provider_e           provider_i,
    input  wire logic [bpu_pkg::hist_len-1:0] history_i,
    input  wire logic                         btb_hit_i,
    input  wire logic [bpu_pkg::xlen-1:0]     btb_target_i,
    output bpu_pkg::pred_t                    pred_o
);

    logic [6:0]               opcode;
    logic [bpu_pkg::xlen-1:0] b_imm;
    logic [bpu_pkg::xlen-1:0] j_imm;
    logic [bpu_pkg::xlen-1:0] pc_plus4;
    logic [bpu_pkg::xlen-1:0] b_target;
    logic [bpu_pkg::xlen-1:0] j_target;

    assign opcode = fetch_inst_i.b.opcode;   // same bits in both views

    // sign extended branch offset
    assign b_imm = {{20{fetch_inst_i.b.imm12}},
                    fetch_inst_i.b.imm11,
                    fetch_inst_i.b.imm10_5,
                    fetch_inst_i.b.imm4_1,
                    1'b0};

    // sign extended jal offset
    assign j_imm = {{12{fetch_inst_i.j.imm20}},
                    fetch_inst_i.j.imm19_12,
                    fetch_inst_i.j.imm11,
                    fetch_inst_i.j.imm10_1,
                    1'b0};

    assign pc_plus4 = fetch_pc_i + 32'd4;
    assign b_target = fetch_pc_i + b_imm;
    assign j_target = fetch_pc_i + j_imm;

    always_comb begin
        pred_o.is_cf    = 1'b0;
        pred_o.taken    = 1'b0;
        pred_o.target   = pc_plus4;
        pred_o.provider = provider_i;
        pred_o.history  = history_i;

        case (opcode)
            bpu_pkg::opc_jal: begin
                pred_o.is_cf  = 1'b1;
                pred_o.taken  = 1'b1;
                pred_o.target = btb_hit_i ? btb_target_i : j_target;
            end
            bpu_pkg::opc_jalr: begin
                // register target unknown here, btb or fall through
                pred_o.is_cf = 1'b1;
                pred_o.taken = btb_hit_i;
                if (btb_hit_i) begin
                    pred_o.target = btb_target_i;
                end
            end
            bpu_pkg::opc_branch: begin
                pred_o.is_cf = 1'b1;
                pred_o.taken = dir_taken_i;
                if (dir_taken_i) begin
                    pred_o.target = btb_hit_i ? btb_target_i : b_target;
                end
            end
            default: ;   // not control flow
        endcase
    end

endmodule

`default_nettype wire

// File: hw/bpu_btb.sv
`default_nettype none

module bpu_btb #(
    parameter int unsigned btb_entries = 256    // power of two
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [bpu_pkg::xlen-1:0] lookup_pc_i,
    input  wire bpu_pkg::resolve_t        resolve_i,
    output logic                          hit_o,
    output logic [bpu_pkg::xlen-1:0]      target_o
);

    localparam int unsigned idx_w = $clog2(btb_entries);
    localparam int unsigned tag_w = bpu_pkg::xlen - 2 - idx_w;

    logic [tag_w-1:0]         tag_mem    [btb_entries];
    logic [bpu_pkg::xlen-1:0] target_mem [btb_entries];
    logic [btb_entries-1:0]   valid_q;

    logic [idx_w-1:0] lk_idx;
    logic [tag_w-1:0] lk_tag;
    logic [idx_w-1:0] wr_idx;
    logic [tag_w-1:0] wr_tag;
    logic             wr_en;

    // word aligned index, remaining upper bits as tag
    assign lk_idx = lookup_pc_i[idx_w+1:2];
    assign lk_tag = lookup_pc_i[bpu_pkg::xlen-1:idx_w+2];
    assign wr_idx = resolve_i.pc[idx_w+1:2];
    assign wr_tag = resolve_i.pc[bpu_pkg::xlen-1:idx_w+2];

    assign wr_en = resolve_i.valid && resolve_i.taken;   // only taken ones fill

    assign hit_o    = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign target_o = target_mem[lk_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= resolve_i.target;
        end
    end

endmodule

`default_nettype wire

// File: hw/bpu_tage.sv
`default_nettype none

module bpu_tage (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [bpu_pkg::xlen-1:0]     lookup_pc_i,
    input  wire bpu_pkg::resolve_t            resolve_i,
    output logic                              dir_taken_o,
    output bpu_pkg::provider_e                provider_o,
    output logic [bpu_pkg::hist_len-1:0]      history_o
);

    localparam int unsigned xlen     = bpu_pkg::xlen;
    localparam int unsigned hist_len = bpu_pkg::hist_len;
    localparam int unsigned tag_len  = bpu_pkg::tag_len;
    localparam int unsigned idx_len  = bpu_pkg::tage_idx_len;
    localparam int unsigned bim_len  = bpu_pkg::bim_idx_len;
    localparam int unsigned ptag_len = bpu_pkg::partial_tag_len;

    localparam int unsigned bim_entries  = 1 << bim_len;
    localparam int unsigned tage_entries = 1 << idx_len;

    typedef logic [idx_len-1:0] tidx_t;
    typedef logic [tag_len-1:0] tag_t;

    logic [hist_len-1:0] ghist;

    bpu_pkg::ctr_t bim_ctr [bim_entries];
    tag_t          t0_tag  [tage_entries];
    bpu_pkg::ctr_t t0_ctr  [tage_entries];
    tag_t          t1_tag  [tage_entries];
    bpu_pkg::ctr_t t1_ctr  [tage_entries];

    // short history slice
    function automatic tidx_t t0_index(input logic [xlen-1:0] pc,
                                       input logic [hist_len-1:0] hist);
        return pc[idx_len-1:0] ^ hist[idx_len-1:0];
    endfunction

    function automatic tag_t t0_tag_of(input logic [xlen-1:0] pc,
                                       input logic [hist_len-1:0] hist);
        return pc[idx_len +: tag_len] ^ hist[hist_len-1 -: tag_len];
    endfunction

    // upper history slice
    function automatic tidx_t t1_index(input logic [xlen-1:0] pc,
                                       input logic [hist_len-1:0] hist);
        return pc[idx_len-1:0] ^ hist[hist_len-1 -: idx_len];
    endfunction

    function automatic tag_t t1_tag_of(input logic [xlen-1:0] pc,
                                       input logic [hist_len-1:0] hist);
        return pc[idx_len +: tag_len] ^ {{(tag_len-idx_len){1'b0}}, hist[idx_len-1:0]};
    endfunction

    function automatic bpu_pkg::ctr_t ctr_step(input bpu_pkg::ctr_t ctr, input logic taken);
        bpu_pkg::ctr_t nxt;
        nxt = ctr;
        if (taken && ctr != bpu_pkg::ctr_strong_t) begin
            nxt = ctr + 2'd1;
        end else if (!taken && ctr != bpu_pkg::ctr_strong_nt) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

    // lookup side
    logic [bim_len-1:0] lk_bim_idx;
    tidx_t              lk_t0_idx;
    tidx_t              lk_t1_idx;
    tag_t               lk_t0_tag;
    tag_t               lk_t1_tag;
    logic               t0_hit;
    logic               t1_hit;

    assign lk_bim_idx = lookup_pc_i[bim_len:1];
    assign lk_t0_idx  = t0_index(lookup_pc_i, ghist);
    assign lk_t1_idx  = t1_index(lookup_pc_i, ghist);
    assign lk_t0_tag  = t0_tag_of(lookup_pc_i, ghist);
    assign lk_t1_tag  = t1_tag_of(lookup_pc_i, ghist);

    // partial match on the tag msbs only
    assign t0_hit = t0_tag[lk_t0_idx][tag_len-1 -: ptag_len] == lk_t0_tag[tag_len-1 -: ptag_len];
    assign t1_hit = t1_tag[lk_t1_idx][tag_len-1 -: ptag_len] == lk_t1_tag[tag_len-1 -: ptag_len];

    always_comb begin
        if (t1_hit) begin  // longest history wins
            provider_o  = bpu_pkg::prov_t1;
            dir_taken_o = t1_ctr[lk_t1_idx][1];
        end else if (t0_hit) begin
            provider_o  = bpu_pkg::prov_t0;
            dir_taken_o = t0_ctr[lk_t0_idx][1];
        end else begin
            provider_o  = bpu_pkg::prov_bim;
            dir_taken_o = bim_ctr[lk_bim_idx][1];
        end
    end

    assign history_o = ghist;

    // update side, indexed with the history carried by the resolve
    logic [bim_len-1:0] up_bim_idx;
    tidx_t              up_t0_idx;
    tidx_t              up_t1_idx;
    tag_t               up_t0_tag;
    tag_t               up_t1_tag;
    bpu_pkg::ctr_t      forced_ctr;
    bpu_pkg::ctr_t      alloc_ctr;

    assign up_bim_idx = resolve_i.pc[bim_len:1];
    assign up_t0_idx  = t0_index(resolve_i.pc, resolve_i.history);
    assign up_t1_idx  = t1_index(resolve_i.pc, resolve_i.history);
    assign up_t0_tag  = t0_tag_of(resolve_i.pc, resolve_i.history);
    assign up_t1_tag  = t1_tag_of(resolve_i.pc, resolve_i.history);
    assign forced_ctr = resolve_i.taken ? bpu_pkg::ctr_strong_t : bpu_pkg::ctr_strong_nt;
    assign alloc_ctr  = resolve_i.taken ? bpu_pkg::ctr_weak_t : bpu_pkg::ctr_weak_nt;

    // history and bimodal train on every resolve
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < bim_entries; i++) begin
                bim_ctr[i] <= bpu_pkg::ctr_weak_nt;
            end
        end else if (resolve_i.valid) begin
            ghist               <= {ghist[hist_len-2:0], resolve_i.taken};
            bim_ctr[up_bim_idx] <= ctr_step(bim_ctr[up_bim_idx], resolve_i.taken);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tage_entries; i++) begin
                t0_tag[i] <= '0;
                t0_ctr[i] <= bpu_pkg::ctr_weak_nt;
                t1_tag[i] <= '0;
                t1_ctr[i] <= bpu_pkg::ctr_weak_nt;
            end
        end else if (resolve_i.valid) begin
            if (resolve_i.correct) begin
                case (resolve_i.provider)
                    bpu_pkg::prov_t1: t1_ctr[up_t1_idx] <= ctr_step(t1_ctr[up_t1_idx],
                                                                    resolve_i.taken);
                    bpu_pkg::prov_t0: t0_ctr[up_t0_idx] <= ctr_step(t0_ctr[up_t0_idx],
                                                                    resolve_i.taken);
                    default: ;
                endcase
            end else begin
                case (resolve_i.provider)
                    bpu_pkg::prov_t1: t1_ctr[up_t1_idx] <= forced_ctr;
                    bpu_pkg::prov_t0: t0_ctr[up_t0_idx] <= forced_ctr;
                    bpu_pkg::prov_bim: begin
                        // allocate, t1 first, full tag compare
                        if (t1_tag[up_t1_idx] != up_t1_tag) begin
                            t1_tag[up_t1_idx] <= up_t1_tag;
                            t1_ctr[up_t1_idx] <= alloc_ctr;
                        end else if (t0_tag[up_t0_idx] != up_t0_tag) begin
                            t0_tag[up_t0_idx] <= up_t0_tag;
                            t0_ctr[up_t0_idx] <= alloc_ctr;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int unsigned xlen            = 32;
    localparam int unsigned hist_len        = 16;
    localparam int unsigned tag_len         = 10;
    localparam int unsigned partial_tag_len = 6;   // msbs compared on lookup
    localparam int unsigned bim_idx_len     = 9;   // 512 entries
    localparam int unsigned tage_idx_len    = 8;   // 256 entries per tagged table

    // 2-bit saturating counter, msb gives the direction
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_strong_nt = 2'b00;
    localparam ctr_t ctr_weak_nt   = 2'b01;
    localparam ctr_t ctr_weak_t    = 2'b10;
    localparam ctr_t ctr_strong_t  = 2'b11;

    typedef enum logic [1:0] {
        prov_bim = 2'd0,
        prov_t0  = 2'd1,
        prov_t1  = 2'd2
    } provider_e;

    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;    // bits 11:7 sit where rd is in the j view
        logic       imm11;
        logic [6:0] opcode;
    } inst_b_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_b_t b;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        logic                is_cf;
        logic                taken;
        logic [xlen-1:0]     target;
        provider_e           provider;
        logic [hist_len-1:0] history;    // history seen at lookup
    } pred_t;

    // record sent back by execute
    typedef struct packed {
        logic                valid;
        logic                taken;
        logic                correct;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     target;
        logic [hist_len-1:0] history;
        provider_e           provider;
    } resolve_t;

endpackage

`default_nettype wire
